//--- all.f
+incdir+.
i2c_bus_pkg.sv
clk_cfg_pkg.sv
i2c_byte_master.sv
i2c_reg_access.sv
clk_chip_configurer.sv
clk_diag_top.sv
tb_bus_checker.sv
tb_clk_diag.sv

//--- clk_cfg_pkg.sv
package clk_cfg_pkg;

   // table entry kind
   typedef enum logic {
      op_write = 1'b0,
      op_poll  = 1'b1
   } cfg_op_e;

   // access direction, value matches the r/w bit of the address byte
   typedef enum logic {
      kind_write = 1'b0,
      kind_read  = 1'b1
   } reg_kind_e;

   // ---------------------------------------------------------------------
   // table word, 17 bits: op in the top bit, register, then payload
   // ---------------------------------------------------------------------
   typedef struct packed { cfg_op_e op; logic [7:0] addr; logic [7:0] value; } cfg_wr_t;
   typedef struct packed { cfg_op_e op; logic [7:0] addr; logic [7:0] mask; } cfg_poll_t;

   typedef union packed {
      cfg_wr_t   wr;
      cfg_poll_t poll;
   } cfg_entry_u;

endpackage

//--- clk_cfg_table.svh
// bring-up sequence for the clock generator
// each word is {op, register, value or mask}
localparam int cfg_table_len = 10;

localparam clk_cfg_pkg::cfg_entry_u cfg_table [cfg_table_len] = '{
   // outputs off, loss-of-lock masked while reprogramming
   {clk_cfg_pkg::op_write, 8'he6, 8'h10},
   {clk_cfg_pkg::op_write, 8'hf1, 8'he5},
   // input and pll setup
   {clk_cfg_pkg::op_write, 8'h1c, 8'h16},
   {clk_cfg_pkg::op_write, 8'h1d, 8'h90},
   // wait for a valid input clock
   {clk_cfg_pkg::op_poll,  8'hda, 8'h04},
   {clk_cfg_pkg::op_write, 8'h31, 8'h10},
   {clk_cfg_pkg::op_write, 8'hf6, 8'h02},
   // wait for pll lock
   {clk_cfg_pkg::op_poll,  8'hda, 8'h11},
   {clk_cfg_pkg::op_write, 8'hf1, 8'h65},
   {clk_cfg_pkg::op_write, 8'he6, 8'h00}
};

//--- clk_chip_configurer.sv
module clk_chip_configurer (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   acc_ack_i,
   input  logic [7:0]             acc_rdata_i,
   input  logic                   acc_fail_i,
   output logic                   acc_req_o,
   output clk_cfg_pkg::reg_kind_e acc_kind_o,
   output logic [7:0]             acc_reg_o,
   output logic [7:0]             acc_wdata_o,
   output logic                   done_o
);
   import clk_cfg_pkg::*;
   `include "clk_cfg_table.svh"

   localparam int iw = (cfg_table_len > 1) ? $clog2(cfg_table_len) : 1;
   localparam logic [iw-1:0] last_idx = iw'(cfg_table_len - 1);

   localparam logic [1:0] st_idle    = 2'd0;
   localparam logic [1:0] st_req     = 2'd1;
   localparam logic [1:0] st_release = 2'd2;
   localparam logic [1:0] st_done    = 2'd3;

   logic [1:0]    state;
   logic [iw-1:0] idx;
   logic          fin;
   cfg_entry_u    entry;
   logic          entry_ok;

   // -------------------------------------------------------------------
   // entry decode
   // -------------------------------------------------------------------
   assign entry       = cfg_table[idx];
   assign acc_kind_o  = (entry.wr.op == op_poll) ? kind_read : kind_write;
   assign acc_reg_o   = entry.wr.addr;
   assign acc_wdata_o = entry.wr.value;

   // a poll passes once every mask bit reads back set
   assign entry_ok = !acc_fail_i &&
                     ((entry.wr.op == op_write) ||
                      ((acc_rdata_i & entry.poll.mask) == entry.poll.mask));

   assign acc_req_o = (state == st_req);
   assign done_o    = (state == st_done);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= st_idle;
         idx   <= '0;
         fin   <= 1'b0;
      end else begin
         case (state)
            st_idle: state <= st_req;
            st_req: begin
               if (acc_ack_i) begin
                  // failed access or pending poll keeps the same index
                  if (entry_ok) begin
                     if (idx == last_idx)
                        fin <= 1'b1;
                     else
                        idx <= idx + 1'b1;
                  end
                  state <= st_release;
               end
            end
            st_release: begin
               if (!acc_ack_i)
                  state <= fin ? st_done : st_req;
            end
            default: ;
         endcase
      end
   end

endmodule

//--- clk_diag_top.sv
module clk_diag_top #(
   parameter logic [6:0] dev_addr = 7'h70,
   parameter int         scl_div  = 4
) (
   input  logic clk,
   input  logic rst_i,
   output logic done_o,
   inout  wire  scl_io,
   inout  wire  sda_io
);
   import i2c_bus_pkg::*;
   import clk_cfg_pkg::*;

   // configurer to sequencer
   logic       acc_req;
   logic       acc_ack;
   reg_kind_e  acc_kind;
   logic [7:0] acc_reg;
   logic [7:0] acc_wdata;
   logic [7:0] acc_rdata;
   logic       acc_fail;

   // sequencer to byte master
   logic       bm_req;
   logic       bm_ack;
   i2c_cmd_e   bm_cmd;
   i2c_byte_t  bm_wbyte;
   i2c_byte_t  bm_rbyte;
   logic       bm_nack_send;
   logic       bm_nack_rcvd;

   clk_chip_configurer clk_chip_configurer_inst (
      .clk         (clk),
      .rst_i       (rst_i),
      .acc_ack_i   (acc_ack),
      .acc_rdata_i (acc_rdata),
      .acc_fail_i  (acc_fail),
      .acc_req_o   (acc_req),
      .acc_kind_o  (acc_kind),
      .acc_reg_o   (acc_reg),
      .acc_wdata_o (acc_wdata),
      .done_o      (done_o)
   );

   i2c_reg_access #(.dev_addr(dev_addr)) i2c_reg_access_inst (
      .clk            (clk),
      .rst_i          (rst_i),
      .acc_req_i      (acc_req),
      .acc_kind_i     (acc_kind),
      .acc_reg_i      (acc_reg),
      .acc_wdata_i    (acc_wdata),
      .bm_ack_i       (bm_ack),
      .bm_rbyte_i     (bm_rbyte),
      .bm_nack_rcvd_i (bm_nack_rcvd),
      .acc_ack_o      (acc_ack),
      .acc_rdata_o    (acc_rdata),
      .acc_fail_o     (acc_fail),
      .bm_req_o       (bm_req),
      .bm_cmd_o       (bm_cmd),
      .bm_wbyte_o     (bm_wbyte),
      .bm_nack_send_o (bm_nack_send)
   );

   i2c_byte_master #(.scl_div(scl_div)) i2c_byte_master_inst (
      .clk            (clk),
      .rst_i          (rst_i),
      .bm_req_i       (bm_req),
      .bm_cmd_i       (bm_cmd),
      .bm_wbyte_i     (bm_wbyte),
      .bm_nack_send_i (bm_nack_send),
      .bm_ack_o       (bm_ack),
      .bm_rbyte_o     (bm_rbyte),
      .bm_nack_rcvd_o (bm_nack_rcvd),
      .scl_io         (scl_io),
      .sda_io         (sda_io)
   );

endmodule

//--- i2c_bus_pkg.sv
package i2c_bus_pkg;

   // -------------------------------------------------------------------
   // byte master command set
   // -------------------------------------------------------------------

   // one command per req/ack handshake
   typedef enum logic [1:0] {
      cmd_start = 2'd0,
      cmd_stop  = 2'd1,
      cmd_write = 2'd2,
      cmd_read  = 2'd3
   } i2c_cmd_e;

   // a single byte as it travels on the bus
   typedef logic [7:0] i2c_byte_t;

endpackage

//--- i2c_byte_master.sv
module i2c_byte_master #(
   parameter int scl_div = 4
) (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  bm_req_i,
   input  i2c_bus_pkg::i2c_cmd_e bm_cmd_i,
   input  i2c_bus_pkg::i2c_byte_t bm_wbyte_i,
   input  logic                  bm_nack_send_i,
   output logic                  bm_ack_o,
   output i2c_bus_pkg::i2c_byte_t bm_rbyte_o,
   output logic                  bm_nack_rcvd_o,
   inout  wire                   scl_io,
   inout  wire                   sda_io
);
   import i2c_bus_pkg::*;

   localparam int dw = $clog2(scl_div + 1);

   localparam logic [2:0] st_idle  = 3'd0;
   localparam logic [2:0] st_start = 3'd1;
   localparam logic [2:0] st_stop  = 3'd2;
   localparam logic [2:0] st_bit   = 3'd3;
   localparam logic [2:0] st_ack   = 3'd4;

   logic [2:0]    state;
   logic [dw-1:0] div_cnt;
   logic          tick;
   logic [1:0]    q;
   logic [3:0]    bit_cnt;
   logic          scl_low;
   logic          sda_low;
   logic          scl_in;
   logic          sda_in;
   i2c_byte_t     sh;
   logic          busy;

   // open drain, lines are pulled low or left floating
   assign scl_io = scl_low ? 1'b0 : 1'bz;
   assign sda_io = sda_low ? 1'b0 : 1'bz;
   assign scl_in = scl_io;
   assign sda_in = sda_io;

   assign busy     = (state == st_start) || (state == st_stop) || (state == st_bit);
   assign tick     = (div_cnt == '0);
   assign bm_ack_o = (state == st_ack);
   // write bytes shift the read-back in, so this is the received byte on reads
   assign bm_rbyte_o = sh;

   // -------------------------------------------------------------------
   // quarter-period sequencer
   // -------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state   <= st_idle;
         div_cnt <= '0;
         q       <= '0;
         bit_cnt <= '0;
         scl_low <= 1'b0;
         sda_low <= 1'b0;
      end else if (state == st_idle) begin
         div_cnt <= '0;
         q       <= '0;
         bit_cnt <= '0;
         if (bm_req_i) begin
            case (bm_cmd_i)
               cmd_start: state <= st_start;
               cmd_stop:  state <= st_stop;
               default:   state <= st_bit;
            endcase
         end
      end else if (state == st_ack) begin
         // hold until the requester lets go
         if (!bm_req_i)
            state <= st_idle;
      end else if (busy) begin
         div_cnt <= tick ? dw'(scl_div - 1) : div_cnt - 1'b1;
         if (tick) begin
            q <= q + 1'b1;
            case (state)
               st_start: begin
                  // releasing sda first also covers the repeated start
                  // where scl is still held low after a byte
                  case (q)
                     2'd0: sda_low <= 1'b0;
                     2'd1: scl_low <= 1'b0;
                     2'd2: sda_low <= 1'b1;
                     default: begin
                        scl_low <= 1'b1;
                        state   <= st_ack;
                     end
                  endcase
               end
               st_stop: begin
                  case (q)
                     2'd0: sda_low <= 1'b1;
                     2'd1: scl_low <= 1'b0;
                     2'd2: sda_low <= 1'b0;
                     default: state <= st_ack;
                  endcase
               end
               default: begin
                  case (q)
                     // drive data or the ack slot while scl is low
                     2'd0: begin
                        if (bit_cnt == 4'd8)
                           sda_low <= (bm_cmd_i == cmd_read) && !bm_nack_send_i;
                        else
                           sda_low <= ~sh[7];
                     end
                     2'd1: scl_low <= 1'b0;
                     2'd2: ;
                     default: begin
                        scl_low <= 1'b1;
                        if (bit_cnt == 4'd8)
                           state <= st_ack;
                        else
                           bit_cnt <= bit_cnt + 1'b1;
                     end
                  endcase
               end
            endcase
         end
      end
   end

   // shift register and ack bit, sampled mid high phase
   always_ff @(posedge clk) begin
      if (state == st_idle && bm_req_i)
         sh <= (bm_cmd_i == cmd_read) ? 8'hff : bm_wbyte_i;
      else if (state == st_bit && tick && q == 2'd2) begin
         if (bit_cnt == 4'd8)
            bm_nack_rcvd_o <= sda_in;
         else
            sh <= {sh[6:0], sda_in};
      end
   end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
      $rose(bm_ack_o) |-> bm_req_i);

   // data only moves under a low clock, start and stop are the exceptions
   a_sda_stable: assert property (@(posedge clk) disable iff (rst_i)
      (state == st_bit) && $past(state == st_bit) && scl_in && $past(scl_in)
      |-> $stable(sda_in));

endmodule

//--- i2c_reg_access.sv
module i2c_reg_access #(
   parameter logic [6:0] dev_addr = 7'h70
) (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   acc_req_i,
   input  clk_cfg_pkg::reg_kind_e acc_kind_i,
   input  logic [7:0]             acc_reg_i,
   input  logic [7:0]             acc_wdata_i,
   input  logic                   bm_ack_i,
   input  i2c_bus_pkg::i2c_byte_t bm_rbyte_i,
   input  logic                   bm_nack_rcvd_i,
   output logic                   acc_ack_o,
   output logic [7:0]             acc_rdata_o,
   output logic                   acc_fail_o,
   output logic                   bm_req_o,
   output i2c_bus_pkg::i2c_cmd_e  bm_cmd_o,
   output i2c_bus_pkg::i2c_byte_t bm_wbyte_o,
   output logic                   bm_nack_send_o
);
   import i2c_bus_pkg::*;
   import clk_cfg_pkg::*;

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_cmd  = 2'd1;
   localparam logic [1:0] st_gap  = 2'd2;
   localparam logic [1:0] st_ack  = 2'd3;

   logic [1:0] state;
   logic [2:0] step;
   logic [2:0] last_step;
   logic       last;
   logic       fail;
   i2c_byte_t  rdata;

   // write: start, addr+w, reg, data, stop
   // read: start, addr+w, reg, start, addr+r, byte, stop
   assign last_step = (acc_kind_i == kind_write) ? 3'd4 : 3'd6;

   always_comb begin
      bm_cmd_o   = cmd_stop;
      bm_wbyte_o = acc_reg_i;
      case (step)
         3'd0: bm_cmd_o = cmd_start;
         3'd1: begin
            bm_cmd_o   = cmd_write;
            bm_wbyte_o = {dev_addr, 1'b0};
         end
         3'd2: bm_cmd_o = cmd_write;
         3'd3: begin
            bm_cmd_o   = (acc_kind_i == kind_write) ? cmd_write : cmd_start;
            bm_wbyte_o = acc_wdata_i;
         end
         3'd4: begin
            bm_cmd_o   = (acc_kind_i == kind_write) ? cmd_stop : cmd_write;
            bm_wbyte_o = {dev_addr, 1'b1};
         end
         3'd5: bm_cmd_o = cmd_read;
         default: bm_cmd_o = cmd_stop;
      endcase
   end

   // single byte reads are always closed with a nack
   assign bm_nack_send_o = (bm_cmd_o == cmd_read);
   assign bm_req_o       = (state == st_cmd);
   assign acc_ack_o      = (state == st_ack);
   assign acc_fail_o     = fail;
   assign acc_rdata_o    = rdata;

   // -------------------------------------------------------------------
   // one byte master handshake per step
   // -------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= st_idle;
         step  <= '0;
         last  <= 1'b0;
         fail  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (acc_req_i) begin
                  step  <= '0;
                  last  <= 1'b0;
                  fail  <= 1'b0;
                  state <= st_cmd;
               end
            end
            st_cmd: begin
               if (bm_ack_i) begin
                  if (step == last_step)
                     last <= 1'b1;
                  else if (bm_cmd_o == cmd_write && bm_nack_rcvd_i) begin
                     // slave refused a byte, go straight to stop
                     fail <= 1'b1;
                     step <= last_step;
                  end else
                     step <= step + 1'b1;
                  state <= st_gap;
               end
            end
            st_gap: begin
               if (!bm_ack_i)
                  state <= last ? st_ack : st_cmd;
            end
            default: begin
               if (!acc_req_i)
                  state <= st_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_cmd && bm_ack_i && bm_cmd_o == cmd_read)
         rdata <= bm_rbyte_i;
   end

   a_acc_stable: assert property (@(posedge clk) disable iff (rst_i)
      acc_req_i && !acc_ack_o && $past(acc_req_i)
      |-> $stable({acc_kind_i, acc_reg_i, acc_wdata_i}));

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_clk_diag \
   --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

//--- tb_bus_checker.sv
module tb_bus_checker (
   input  logic       clk,
   input  logic       rst_i,
   input  logic       scl_i,
   input  logic       sda_i,
   input  logic       done_i,
   input  logic [2:0] poll_need_i,
   output int         value_errs_o,
   output int         proto_errs_o,
   output int         nacks_o
);
   import clk_cfg_pkg::*;
   `include "clk_cfg_table.svh"

   localparam logic [7:0] addr_wr = {7'h70, 1'b0};
   localparam logic [7:0] addr_rd = {7'h70, 1'b1};

   logic       scl_q;
   logic       sda_q;
   logic       start_c;
   logic       stop_c;
   logic       in_xfer;
   logic       seen_start;
   logic       done_seen;
   // repeated start seen inside the current transaction
   logic       rs;
   logic       nacked;
   logic [7:0] shreg;
   logic [7:0] xfer_bytes [4];
   int         bit_cnt;
   int         nbytes;
   // running table position and successful reads of the current poll
   int         ent;
   int         reads;

   // ---------------------------------------------------------------------
   // reference model of the table walk
   // ---------------------------------------------------------------------

   // expected table word for a running entry index
   function automatic cfg_entry_u expected_entry(input int idx);
      return cfg_table[idx];
   endfunction

   // poll is satisfied once every mask bit reads back as one
   function automatic logic poll_ready(input logic [7:0] data, input logic [7:0] mask);
      return (data & mask) == mask;
   endfunction

   task automatic value_mismatch(input string sig, input int got, input int exp);
      $display("ERROR %0t %s: got %0h expected %0h", $time, sig, got, exp);
      value_errs_o++;
   endtask

   task automatic protocol_fault(input string what);
      $display("protocol problem at time %0t: %s", $time, what);
      proto_errs_o++;
   endtask

   // nine bits in, the last one is the acknowledge slot
   task automatic byte_done(input logic ack_bit);
      if (nacked)
         protocol_fault("byte sent after a NACK instead of a stop");
      if (nbytes < 4)
         xfer_bytes[nbytes] = shreg;
      // data byte of a read is answered by the master, always with NACK
      if (rs && nbytes == 3) begin
         if (!ack_bit)
            protocol_fault("single read byte answered with ACK");
      end else if (ack_bit)
         nacked = 1'b1;
      nbytes++;
   endtask

   // judge one transaction at its stop
   task automatic finish_transfer();
      cfg_entry_u e;
      if (nacked)
         nacks_o++;
      else if (ent >= cfg_table_len)
         protocol_fault("bus transaction after the last table entry");
      else begin
         e = expected_entry(ent);
         if (e.wr.op == op_write) begin
            if (rs || nbytes != 3)
               protocol_fault("write entry did not show up as a three byte write");
            else begin
               if (xfer_bytes[0] != addr_wr)
                  value_mismatch("address byte", int'(xfer_bytes[0]), int'(addr_wr));
               if (xfer_bytes[1] != e.wr.addr)
                  value_mismatch("write register", int'(xfer_bytes[1]), int'(e.wr.addr));
               if (xfer_bytes[2] != e.wr.value)
                  value_mismatch("write value", int'(xfer_bytes[2]), int'(e.wr.value));
            end
            // a wrong write still consumes its entry so errors do not cascade
            ent++;
         end else if (!rs || nbytes != 4)
            protocol_fault("poll entry did not show up as a register read");
         else begin
            if (xfer_bytes[0] != addr_wr)
               value_mismatch("address byte", int'(xfer_bytes[0]), int'(addr_wr));
            if (xfer_bytes[1] != e.poll.addr)
               value_mismatch("poll register", int'(xfer_bytes[1]), int'(e.poll.addr));
            if (xfer_bytes[2] != addr_rd)
               value_mismatch("read address byte", int'(xfer_bytes[2]), int'(addr_rd));
            reads++;
            if (poll_ready(xfer_bytes[3], e.poll.mask)) begin
               if (reads != int'(poll_need_i))
                  value_mismatch("poll read count", reads, int'(poll_need_i));
               reads = 0;
               ent++;
            end
         end
      end
   endtask

   // ---------------------------------------------------------------------
   // bus decode, lines sampled on the clock
   // ---------------------------------------------------------------------
   always @(posedge clk) begin
      if (rst_i) begin
         scl_q        = 1'b1;
         sda_q        = 1'b1;
         in_xfer      = 1'b0;
         seen_start   = 1'b0;
         done_seen    = 1'b0;
         rs           = 1'b0;
         nacked       = 1'b0;
         bit_cnt      = 0;
         nbytes       = 0;
         ent          = 0;
         reads        = 0;
         value_errs_o = 0;
         proto_errs_o = 0;
         nacks_o      = 0;
      end else begin
         start_c = scl_q && scl_i && sda_q && !sda_i;
         stop_c  = scl_q && scl_i && !sda_q && sda_i;
         // quiet bus and low done until the very first start
         if (!seen_start && !start_c && (!scl_i || !sda_i || done_i)) begin
            protocol_fault("bus or done_o active before the first start");
            seen_start = 1'b1;
         end
         if (done_i && !done_seen) begin
            done_seen = 1'b1;
            if (ent != cfg_table_len)
               value_mismatch("completed table entries", ent, cfg_table_len);
            if (in_xfer)
               protocol_fault("done_o rose in the middle of a transaction");
         end else if (done_seen && !done_i) begin
            protocol_fault("done_o fell after it had risen");
            done_seen = 1'b0;
         end
         if (start_c) begin
            if (done_seen)
               protocol_fault("start condition after done_o");
            if (in_xfer) begin
               if (nacked)
                  protocol_fault("repeated start after a NACK instead of a stop");
               rs = 1'b1;
            end else begin
               rs     = 1'b0;
               nacked = 1'b0;
               nbytes = 0;
            end
            in_xfer    = 1'b1;
            seen_start = 1'b1;
            bit_cnt    = 0;
         end else if (stop_c) begin
            if (in_xfer)
               finish_transfer();
            in_xfer = 1'b0;
         end else if (in_xfer && !scl_q && scl_i) begin
            if (bit_cnt < 8) begin
               shreg = {shreg[6:0], sda_i};
               bit_cnt++;
            end else begin
               byte_done(sda_i);
               bit_cnt = 0;
            end
         end
         scl_q = scl_i;
         sda_q = sda_i;
      end
   end

endmodule

//--- tb_clk_diag.sv
module tb_clk_diag;

   localparam logic [6:0] slave_addr   = 7'h70;
   localparam logic [7:0] status_reg   = 8'hda;
   // input valid in bit 2 and pll lock in bits 0 and 4
   localparam logic [7:0] ready_bits   = 8'h15;
   localparam int         done_timeout = 200000;

   logic        clk;
   logic        rst_i;
   logic        done_o;
   wire         scl_io;
   wire         sda_io;

   // slave model state
   logic        slave_sda_low = 1'b0;
   logic [31:0] lfsr = 32'hc150;
   logic [7:0]  regs [256];
   logic        s_scl;
   logic        s_sda;
   logic        active;
   logic        tx;
   logic        tx_next;
   logic        nxt_low;
   logic        ack_now;
   int          bit_cnt;
   int          byte_no;
   logic [7:0]  rx_byte;
   logic [7:0]  tx_byte;
   logic [7:0]  ptr;
   logic [2:0]  poll_need;
   logic [2:0]  poll_left;

   int          value_errs;
   int          proto_errs;
   int          nacks;
   int          timeouts;
   int          cycles;

   // open drain bus with pull-ups here and a slave that only ever pulls sda low
   pullup (scl_io);
   pullup (sda_io);
   assign sda_io = slave_sda_low ? 1'b0 : 1'bz;

   always #2 clk = ~clk;

   clk_diag_top #(.dev_addr(slave_addr), .scl_div(4)) clk_diag_top_inst (
      .clk    (clk),
      .rst_i  (rst_i),
      .done_o (done_o),
      .scl_io (scl_io),
      .sda_io (sda_io)
   );

   tb_bus_checker tb_bus_checker_inst (
      .clk          (clk),
      .rst_i        (rst_i),
      .scl_i        (scl_io),
      .sda_i        (sda_io),
      .done_i       (done_o),
      .poll_need_i  (poll_need),
      .value_errs_o (value_errs),
      .proto_errs_o (proto_errs),
      .nacks_o      (nacks)
   );

   // ---------------------------------------------------------------------
   // random source
   // ---------------------------------------------------------------------

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken
   task automatic draw_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[6:0], lfsr[0]};
      end
   endtask

   // ---------------------------------------------------------------------
   // clock chip model
   // ---------------------------------------------------------------------

   // roughly one in eight bytes written by the master gets a NACK
   task automatic take_byte(output logic ack);
      logic [7:0] r;
      draw_bits(3, r);
      ack = (r[2:0] != 3'b000);
      if (byte_no == 0) begin
         if (rx_byte[7:1] != slave_addr)
            ack = 1'b0;
         tx_next = ack && rx_byte[0];
      end else if (ack && byte_no == 1)
         ptr = rx_byte;
      else if (ack)
         regs[ptr] = rx_byte;
   endtask

   // status turns ready on the n-th read with n picked fresh for every poll
   task automatic load_read_byte();
      logic [7:0] r;
      if (ptr == status_reg) begin
         if (poll_left == 3'd0) begin
            draw_bits(2, r);
            poll_need = {1'b0, r[1:0]} + 3'd1;
            poll_left = poll_need;
         end
         poll_left = poll_left - 3'd1;
         draw_bits(8, r);
         tx_byte = (poll_left == 3'd0) ? (r | ready_bits) : (r & ~ready_bits);
      end else
         tx_byte = regs[ptr];
   endtask

   always @(posedge clk) begin
      nxt_low = slave_sda_low;
      if (rst_i) begin
         active    = 1'b0;
         tx        = 1'b0;
         tx_next   = 1'b0;
         bit_cnt   = 0;
         byte_no   = 0;
         poll_need = 3'd0;
         poll_left = 3'd0;
         nxt_low   = 1'b0;
         for (int i = 0; i < 256; i++)
            regs[i] = 8'(i) ^ 8'h5a;
      end else if (s_scl && scl_io && s_sda && !sda_io) begin
         // start or repeated start
         // the scl fall that closes the start opens byte 0 like the end of an ack slot
         active  = 1'b1;
         tx      = 1'b0;
         tx_next = 1'b0;
         bit_cnt = 8;
         byte_no = -1;
         nxt_low = 1'b0;
      end else if (s_scl && scl_io && !s_sda && sda_io) begin
         active  = 1'b0;
         tx      = 1'b0;
         nxt_low = 1'b0;
      end else if (active && !s_scl && scl_io) begin
         if (bit_cnt < 8)
            rx_byte = {rx_byte[6:0], sda_io};
      end else if (active && s_scl && !scl_io) begin
         // every change of sda happens right after scl falls
         if (bit_cnt < 7) begin
            bit_cnt++;
            if (tx)
               nxt_low = !tx_byte[7 - bit_cnt];
         end else if (bit_cnt == 7) begin
            bit_cnt = 8;
            if (tx)
               nxt_low = 1'b0;
            else begin
               take_byte(ack_now);
               nxt_low = ack_now;
            end
         end else begin
            bit_cnt = 0;
            byte_no++;
            tx      = tx_next;
            tx_next = 1'b0;
            if (tx) begin
               load_read_byte();
               nxt_low = !tx_byte[7];
            end else
               nxt_low = 1'b0;
         end
      end
      s_scl = scl_io;
      s_sda = sda_io;
      #1;
      slave_sda_low = nxt_low;
   end

   // ---------------------------------------------------------------------
   // reset, wait for done, verdict
   // ---------------------------------------------------------------------
   initial begin
      clk      = 1'b0;
      rst_i    = 1'b1;
      timeouts = 0;
      repeat (5) @(posedge clk);
      #1;
      rst_i  = 1'b0;
      cycles = 0;
      while (!done_o && cycles < done_timeout) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!done_o) begin
         timeouts++;
         $display("done_o did not rise within %0d clock cycles", done_timeout);
      end else begin
         // idle stretch so a late access or a falling done_o is caught
         repeat (500) @(posedge clk);
      end
      $display("closing count: %0d value errors, %0d protocol errors, %0d timeouts, %0d NACKs",
               value_errs, proto_errs, timeouts, nacks);
      if (value_errs + proto_errs + timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
